/* project.f */
+incdir+verification
logic/sys_pkg.sv
logic/host_cmd_decoder.sv
logic/video_window_calc.sv
logic/sync_polarity_fix.sv
logic/csync_gen.sv
logic/video_ctrl_top.sv
verification/tb_video_ctrl.sv

/* verification/tb_model.svh */
// Helpers included inside tb_video_ctrl, after its signals and counters are declared
// Host words are driven one at a time and each waits for its acknowledge

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Shadow of the decoder registers as written by the host
coord_t      sh_width;
coord_t      sh_height;
coord_t      sh_vset;
coord_t      sh_hset;
logic        sh_fs;
coord_t      sh_arc [0:3];
io_word_t    cmd_args [0:15];
logic [31:0] lfsr_state;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	int          i;
	r = '0;
	for (i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

//////////////////////////////////////////////////////////////////////
// Host channel driver
//////////////////////////////////////////////////////////////////////

task automatic send_word(input io_word_t word);
	int wait_cnt;
	@(posedge clk_sys);
	i_io_din <= word;
	@(posedge clk_sys);
	i_io_clk <= 1'b1;
	wait_cnt = 0;
	while (o_io_ack !== 1'b1 && wait_cnt < 6) begin
		@(negedge clk_sys);
		wait_cnt++;
	end
	assert (o_io_ack === 1'b1) else begin
		$display("No acknowledge for host word 0x%04h within 6 cycles", word);
		ack_errors++;
	end
	@(posedge clk_sys);
	i_io_clk <= 1'b0;
	wait_cnt = 0;
	while (o_io_ack !== 1'b0 && wait_cnt < 6) begin
		@(negedge clk_sys);
		wait_cnt++;
	end
	assert (o_io_ack === 1'b0) else begin
		$display("Acknowledge stayed high after host word 0x%04h", word);
		ack_errors++;
	end
endtask

// Command byte followed by n words from cmd_args
task automatic send_cmd(input cmd_code_t code, input int n);
	int i;
	@(posedge clk_sys);
	i_io_uio <= 1'b1;
	repeat (2) @(posedge clk_sys);
	send_word({8'h00, code});
	for (i = 0; i < n; i++)
		send_word(cmd_args[i]);
	@(posedge clk_sys);
	i_io_uio <= 1'b0;
	repeat (3) @(posedge clk_sys);
endtask

//////////////////////////////////////////////////////////////////////
// Window reference model
//////////////////////////////////////////////////////////////////////

task automatic compute_window(input coord_t arx, input coord_t ary,
	output coord_t hmin, output coord_t hmax, output coord_t vmin, output coord_t vmax);
	int eff_w, eff_h, rx, ry, pw, ph, hoff, voff;
	eff_h = (sh_vset != 0 && sh_vset < sh_height) ? sh_vset : sh_height;
	eff_w = (sh_hset != 0 && sh_hset < sh_width) ? sh_hset : sh_width;
	rx = arx;
	ry = ary;
	if (ary == 0) begin
		// Preset codes 1 and 2, anything else means no ratio
		rx = (arx == 1) ? sh_arc[0] : (arx == 2) ? sh_arc[2] : 0;
		ry = (arx == 1) ? sh_arc[1] : (arx == 2) ? sh_arc[3] : 0;
	end
	if (sh_fs || rx == 0 || ry == 0) begin
		pw = eff_w;
		ph = eff_h;
	end else begin
		pw = (eff_h * rx) / ry;
		ph = (eff_w * ry) / rx;
		if (pw > eff_w)
			pw = eff_w;
		if (ph > eff_h)
			ph = eff_h;
	end
	hoff = (sh_width - pw) / 2;
	voff = (sh_height - ph) / 2;
	hmin = coord_t'(hoff);
	hmax = coord_t'(hoff + pw - 1);
	vmin = coord_t'(voff);
	vmax = coord_t'(voff + ph - 1);
endtask

`endif

/* verification/tb_video_ctrl.sv */
// Random host commands and ratios checked against a window model, then sync cleanup checks
// Vertical sync stays inactive, so composite sync is only checked outside vsync
`timescale 1ns/1ps

module tb_video_ctrl
	import sys_pkg::*;
();

	localparam int CLK_PERIOD      = 4;
	localparam int SETTLE_CYCLES   = 2 * CALC_PHASES + 4;
	localparam int N_MODE          = 16;
	// Mode, VSET and HSET per loop plus ARC, two HSET and one unknown command
	localparam int HOST_WORDS      = N_MODE * 14 + 5 + 8;
	localparam int WORD_CYCLES     = 16;
	localparam int SYNC_CYCLES     = 12 * 70;
	localparam int MARGIN_CYCLES   = (N_MODE + 8) * (SETTLE_CYCLES + 8) + 500;
	localparam int WATCHDOG_CYCLES = HOST_WORDS * WORD_CYCLES + SYNC_CYCLES + MARGIN_CYCLES;

	logic     clk_sys;
	logic     resetd;
	logic     i_io_uio, i_io_clk;
	io_word_t i_io_din;
	coord_t   i_arx, i_ary;
	logic     i_hs, i_vs;
	logic     o_io_ack, o_hs, o_vs, o_csync;
	coord_t   o_hmin, o_hmax, o_vmin, o_vmax;

	int       value_errors;
	int       ack_errors;
	logic     sync_check_en;
	logic     hs_pol_exp;
	logic     prev_hs;

	`include "tb_model.svh"

	video_ctrl_top u_video_ctrl_top (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_io_uio(i_io_uio),
		.i_io_clk(i_io_clk),
		.i_io_din(i_io_din),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.i_hs    (i_hs),
		.i_vs    (i_vs),
		.o_io_ack(o_io_ack),
		.o_hs    (o_hs),
		.o_vs    (o_vs),
		.o_csync (o_csync),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp);
			value_errors++;
		end
	endtask

	// Apply a ratio and compare all four edges after two calculator loops
	task automatic ratio_check(input coord_t x, input coord_t y);
		coord_t hmin, hmax, vmin, vmax;
		@(posedge clk_sys);
		i_arx <= x;
		i_ary <= y;
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		compute_window(x, y, hmin, hmax, vmin, vmax);
		check_coord("o_hmin", o_hmin, hmin);
		check_coord("o_hmax", o_hmax, hmax);
		check_coord("o_vmin", o_vmin, vmin);
		check_coord("o_vmax", o_vmax, vmax);
	endtask

	// Six periods checked from the third on
	// Idle runs always beat pulse runs
	task automatic sync_test(input logic pulse_high);
		int p, pulse_len, idle_len;
		for (p = 0; p < 6; p++) begin
			pulse_len = 2 + rand_bits(4);
			idle_len  = 20 + rand_bits(5);
			if (p == 2) begin
				hs_pol_exp    = ~pulse_high;
				sync_check_en = 1'b1;
			end
			repeat (pulse_len) begin
				@(posedge clk_sys);
				i_hs <= pulse_high;
			end
			repeat (idle_len) begin
				@(posedge clk_sys);
				i_hs <= ~pulse_high;
			end
		end
		sync_check_en = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sync checker sampled away from the active edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (sync_check_en) begin
			assert (o_hs === (i_hs ^ hs_pol_exp)) else begin
				$display("Mismatch o_hs: got 0x%0h expected 0x%0h", o_hs, i_hs ^ hs_pol_exp);
				value_errors++;
			end
			assert (o_vs === 1'b0) else begin
				$display("Mismatch o_vs: got 0x%0h expected 0x0", o_vs);
				value_errors++;
			end
			assert (o_csync === prev_hs) else begin
				$display("Mismatch o_csync: got 0x%0h expected 0x%0h", o_csync, prev_hs);
				value_errors++;
			end
		end
		prev_hs = o_hs;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		coord_t w, h;
		int     k;
		clk_sys       = 1'b0;
		resetd        = 1'b1;
		i_io_uio      = 1'b0;
		i_io_clk      = 1'b0;
		i_io_din      = '0;
		i_arx         = '0;
		i_ary         = '0;
		i_hs          = 1'b0;
		i_vs          = 1'b0;
		value_errors  = 0;
		ack_errors    = 0;
		sync_check_en = 1'b0;
		hs_pol_exp    = 1'b0;
		prev_hs       = 1'b0;
		lfsr_state    = 32'h67d8_25c3;
		sh_width      = DEFAULT_WIDTH;
		sh_height     = DEFAULT_HEIGHT;
		sh_vset       = '0;
		sh_hset       = '0;
		sh_fs         = 1'b0;
		for (k = 0; k < 4; k++)
			sh_arc[k] = '0;
		repeat (16) @(posedge clk_sys);
		resetd <= 1'b0;

		// Default mode without a ratio
		ratio_check(12'd0, 12'd0);

		for (int n = 0; n < N_MODE; n++) begin
			w = coord_t'(64 + rand_bits(11) % 1984);
			h = coord_t'(64 + rand_bits(11) % 1984);
			for (k = 0; k < 9; k++)
				cmd_args[k] = io_word_t'(rand_bits(16));
			cmd_args[0] = {cmd_args[0][15:12], w};
			cmd_args[4] = {cmd_args[4][15:12], h};
			send_cmd(CMD_VIDEO_MODE, 9);
			sh_width  = w;
			sh_height = h;
			sh_vset = rand_bits(1) ? coord_t'(rand_bits(11)) : '0;
			cmd_args[0] = {4'h0, sh_vset};
			send_cmd(CMD_VSET, 1);
			sh_hset = rand_bits(1) ? coord_t'(rand_bits(11)) : '0;
			cmd_args[0] = {1'b0, 3'(rand_bits(3)), sh_hset};
			send_cmd(CMD_HSET, 1);
			ratio_check(coord_t'(1 + rand_bits(4)), coord_t'(1 + rand_bits(4)));
		end

		// Aspect presets with code 3 selecting none
		for (k = 0; k < 4; k++) begin
			sh_arc[k]   = coord_t'(1 + rand_bits(4));
			cmd_args[k] = {4'h0, sh_arc[k]};
		end
		send_cmd(CMD_ARC, 4);
		ratio_check(12'd1, 12'd0);
		ratio_check(12'd2, 12'd0);
		ratio_check(12'd3, 12'd0);

		// Free-scale and then an unknown command on top of it
		sh_hset = coord_t'(rand_bits(11));
		sh_fs   = 1'b1;
		cmd_args[0] = {1'b1, 3'b000, sh_hset};
		send_cmd(CMD_HSET, 1);
		ratio_check(coord_t'(1 + rand_bits(4)), coord_t'(1 + rand_bits(4)));
		for (k = 0; k < 3; k++)
			cmd_args[k] = io_word_t'(rand_bits(16));
		send_cmd(8'h55, 3);
		ratio_check(i_arx, i_ary);
		sh_hset = '0;
		sh_fs   = 1'b0;
		cmd_args[0] = 16'h0000;
		send_cmd(CMD_HSET, 1);
		ratio_check(i_arx, i_ary);

		// Active-low then active-high horizontal sync
		sync_test(1'b0);
		sync_test(1'b1);

		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d value mismatches, %0d handshake failures",
			value_errors, ack_errors);
		if (value_errors == 0 && ack_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* logic/video_ctrl_top.sv */
// Video control block on clk_sys with host command decoder, window calculator and sync cleanup
// Syncs from the core may have either polarity and come out active high
`timescale 1ns/1ps

module video_ctrl_top
	import sys_pkg::*;
(
	input  logic     clk_sys,
	input  logic     resetd,
	input  logic     i_io_uio,
	input  logic     i_io_clk,
	input  io_word_t i_io_din,
	input  coord_t   i_arx,
	input  coord_t   i_ary,
	input  logic     i_hs,
	input  logic     i_vs,
	output logic     o_io_ack,
	output logic     o_hs,
	output logic     o_vs,
	output logic     o_csync,
	output coord_t   o_hmin,
	output coord_t   o_hmax,
	output coord_t   o_vmin,
	output coord_t   o_vmax
);

	coord_t width, height, vset, hset;
	coord_t arc1x, arc1y, arc2x, arc2y;
	logic   freescale;

	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_clk   (i_io_clk),
		.i_io_din   (i_io_din),
		.o_io_ack   (o_io_ack),
		.o_width    (width),
		.o_height   (height),
		.o_vset     (vset),
		.o_hset     (hset),
		.o_freescale(freescale),
		.o_arc1x    (arc1x),
		.o_arc1y    (arc1y),
		.o_arc2x    (arc2x),
		.o_arc2y    (arc2y)
	);

	video_window_calc u_video_window_calc (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_width    (width),
		.i_height   (height),
		.i_vset     (vset),
		.i_hset     (hset),
		.i_freescale(freescale),
		.i_arc1x    (arc1x),
		.i_arc1y    (arc1y),
		.i_arc2x    (arc2x),
		.i_arc2y    (arc2y),
		.i_arx      (i_arx),
		.i_ary      (i_ary),
		.o_hmin     (o_hmin),
		.o_hmax     (o_hmax),
		.o_vmin     (o_vmin),
		.o_vmax     (o_vmax)
	);

	// Polarity cleanup per sync
	sync_polarity_fix u_fix_h (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_hs),
		.o_sync (o_hs)
	);

	sync_polarity_fix u_fix_v (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_vs),
		.o_sync (o_vs)
	);

	csync_gen u_csync_gen (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_hsync(o_hs),
		.i_vsync(o_vs),
		.o_csync(o_csync)
	);

endmodule

/* logic/csync_gen.sv */
// Composite sync from active-high horizontal and vertical syncs
// During vsync the hsync pulse moves by one line, outside it hsync passes with one cycle delay
`timescale 1ns/1ps

module csync_gen
	import sys_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	logic     prev_hs;
	logic     hs_q, vs_q;
	run_len_t h_cnt;
	run_len_t line_len, hs_len;

	assign o_csync = hs_q ^ vs_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			prev_hs <= i_hsync;
			if (h_cnt != '1)
				h_cnt <= h_cnt + 1'b1;

			// Measure line and pulse lengths at each edge
			if (prev_hs != i_hsync) begin
				h_cnt <= '0;
				if (i_hsync) begin
					line_len <= h_cnt - hs_len;
					hs_q     <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			if (!i_vsync)
				hs_q <= i_hsync;
			else if (h_cnt == line_len)
				hs_q <= 1'b1;

			vs_q <= i_vsync;
		end
	end

endmodule

/* logic/sync_polarity_fix.sv */
// Output is the raw sync XOR a learned polarity, valid after two full sync periods
// Assumes the sync pulse is the shorter of the two levels
`timescale 1ns/1ps

module sync_polarity_fix
	import sys_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic     s1, s2;
	run_len_t run_cnt;
	run_len_t high_len, low_len;
	logic     pol;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rise ends a low run, fall ends a high run
			if (!s2 && s1)
				low_len <= run_cnt;
			if (s2 && !s1)
				high_len <= run_cnt;
			if (s2 != s1)
				run_cnt <= '0;
			else if (run_cnt != '1)
				run_cnt <= run_cnt + 1'b1;
			// Longer high level means an active-low pulse
			pol <= high_len > low_len;
		end
	end

endmodule

/* logic/video_window_calc.sv */
// Free-running calculation of the centred output window, one result every CALC_PHASES cycles
// Outputs stay 0 after reset until the first phase 7 write
`timescale 1ns/1ps

module video_window_calc
	import sys_pkg::*;
(
	input  logic   clk_sys,
	input  logic   resetd,
	input  coord_t i_width,
	input  coord_t i_height,
	input  coord_t i_vset,
	input  coord_t i_hset,
	input  logic   i_freescale,
	input  coord_t i_arc1x,
	input  coord_t i_arc1y,
	input  coord_t i_arc2x,
	input  coord_t i_arc2y,
	input  coord_t i_arx,
	input  coord_t i_ary,
	output coord_t o_hmin,
	output coord_t o_hmax,
	output coord_t o_vmin,
	output coord_t o_vmax
);

	logic [$clog2(CALC_PHASES)-1:0] phase;

	coord_t mode_w, mode_h;
	coord_t eff_w, eff_h;
	coord_t ar_x, ar_y;
	logic   fs_q;
	calc_t  wcalc, hcalc;
	coord_t pic_w, pic_h;
	coord_t h_off, v_off;

	// Offsets of the picture inside the active area
	assign h_off = (mode_w - pic_w) >> 1;
	assign v_off = (mode_h - pic_h) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			phase <= '0;
		else if (phase == CALC_PHASES - 1)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Input capture, ratio and clamp
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		case (phase)
			0: begin
				mode_w <= i_width;
				mode_h <= i_height;
				fs_q   <= i_freescale;
				// Size limits apply only when below the mode
				eff_h  <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
				eff_w  <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
				if (i_ary == '0) begin
					// Zero ary selects a preset by arx
					if (i_arx == 12'd1) begin
						ar_x <= i_arc1x;
						ar_y <= i_arc1y;
					end else if (i_arx == 12'd2) begin
						ar_x <= i_arc2x;
						ar_y <= i_arc2y;
					end else begin
						ar_x <= '0;
						ar_y <= '0;
					end
				end else begin
					ar_x <= i_arx;
					ar_y <= i_ary;
				end
			end
			1: begin
				if (fs_q || ar_x == '0 || ar_y == '0) begin
					wcalc <= calc_t'(eff_w);
					hcalc <= calc_t'(eff_h);
				end else begin
					// Dividers have until phase 6 to settle
					wcalc <= (calc_t'(eff_h) * calc_t'(ar_x)) / calc_t'(ar_y);
					hcalc <= (calc_t'(eff_w) * calc_t'(ar_y)) / calc_t'(ar_x);
				end
			end
			CALC_PHASES - 2: begin
				pic_w <= (wcalc > calc_t'(eff_w)) ? eff_w : coord_t'(wcalc);
				pic_h <= (hcalc > calc_t'(eff_h)) ? eff_h : coord_t'(hcalc);
			end
			default: ;
		endcase
	end

	// Window registers
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else if (phase == CALC_PHASES - 1) begin
			o_hmin <= h_off;
			o_hmax <= h_off + pic_w - coord_t'(1);
			o_vmin <= v_off;
			o_vmax <= v_off + pic_h - coord_t'(1);
		end
	end

	// A non-empty picture never gives an inverted window
	a_window_order: assert property (@(posedge clk_sys) disable iff (resetd)
		(phase == CALC_PHASES - 1 && pic_w != '0) |=> o_hmax >= o_hmin);

endmodule

/* logic/host_cmd_decoder.sv */
// Host levels pass through two registers, so a word lands 4 cycles after the i_io_clk rise
// The host holds i_io_din around each rise and toggles i_io_clk at most every 4 cycles
// Only the video mode, VSET, HSET and aspect preset commands change state
`timescale 1ns/1ps

module host_cmd_decoder
	import sys_pkg::*;
(
	input  logic     clk_sys,
	input  logic     resetd,
	input  logic     i_io_uio,
	input  logic     i_io_clk,
	input  io_word_t i_io_din,
	output logic     o_io_ack,
	output coord_t   o_width,
	output coord_t   o_height,
	output coord_t   o_vset,
	output coord_t   o_hset,
	output logic     o_freescale,
	output coord_t   o_arc1x,
	output coord_t   o_arc1y,
	output coord_t   o_arc2x,
	output coord_t   o_arc2y
);

	//////////////////////////////////////////////////////////////////////
	// Input synchronisers and word strobe
	//////////////////////////////////////////////////////////////////////

	logic       uio_s1, uio_s2;
	logic       clk_s1, clk_s2, clk_d3;
	io_word_t   din_s1, din_s2;
	io_word_t   din_q;
	logic       io_strobe;
	cmd_state_e state;
	cmd_code_t  cmd;
	arg_cnt_t   arg_cnt;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			uio_s1    <= 1'b0;
			uio_s2    <= 1'b0;
			clk_s1    <= 1'b0;
			clk_s2    <= 1'b0;
			clk_d3    <= 1'b0;
			io_strobe <= 1'b0;
			o_io_ack  <= 1'b0;
		end else begin
			uio_s1    <= i_io_uio;
			uio_s2    <= uio_s1;
			clk_s1    <= i_io_clk;
			clk_s2    <= clk_s1;
			clk_d3    <= clk_s2;
			io_strobe <= clk_s2 & ~clk_d3;
			// Ack is the clock level, four cycles late
			o_io_ack  <= clk_d3;
		end
	end

	// Data word is caught at the same point as the clock rise
	always_ff @(posedge clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
		if (clk_s2 && !clk_d3)
			din_q <= din_s2;
	end

	//////////////////////////////////////////////////////////////////////
	// Command FSM and mode registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= CMD_IDLE;
			cmd         <= '0;
			arg_cnt     <= '0;
			o_width     <= DEFAULT_WIDTH;
			o_height    <= DEFAULT_HEIGHT;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (!uio_s2) begin
			state <= CMD_IDLE;
		end else if (io_strobe) begin
			case (state)
				CMD_IDLE: begin
					cmd     <= din_q[7:0];
					arg_cnt <= '0;
					state   <= CMD_ARGS;
				end
				CMD_ARGS: begin
					// Count sticks at its top value on very long commands
					if (arg_cnt != '1)
						arg_cnt <= arg_cnt + 1'b1;
					case (cmd)
						CMD_VIDEO_MODE: begin
							// Porch and sync words are skipped
							if (arg_cnt == 8'd0)
								o_width <= din_q[11:0];
							if (arg_cnt == 8'd4)
								o_height <= din_q[11:0];
						end
						CMD_VSET: begin
							if (arg_cnt == 8'd0)
								o_vset <= din_q[11:0];
						end
						CMD_HSET: begin
							if (arg_cnt == 8'd0) begin
								o_hset      <= din_q[11:0];
								o_freescale <= din_q[15];
							end
						end
						CMD_ARC: begin
							case (arg_cnt)
								8'd0: o_arc1x <= din_q[11:0];
								8'd1: o_arc1y <= din_q[11:0];
								8'd2: o_arc2x <= din_q[11:0];
								8'd3: o_arc2y <= din_q[11:0];
								default: ;
							endcase
						end
						default: ;
					endcase
				end
				default: state <= CMD_IDLE;
			endcase
		end
	end

	// Argument count only grows within one command
	a_arg_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (resetd)
		(state == CMD_ARGS && $past(state) == CMD_ARGS) |-> arg_cnt >= $past(arg_cnt));

endmodule

/* logic/sys_pkg.sv */
// Shared widths, host command codes, reset mode and FSM states of the video-control block
// Coordinates are 12 bits, so sizes and window positions stay below 4096

package sys_pkg;

	// Pixel or line coordinate and size
	typedef logic [11:0] coord_t;
	// One word of the host I/O channel
	typedef logic [15:0] io_word_t;
	// Command byte and argument counter
	typedef logic [7:0] cmd_code_t;
	typedef logic [7:0] arg_cnt_t;
	// Window products and quotients
	typedef logic [31:0] calc_t;
	// Run length of a sync level in clock cycles
	typedef logic [15:0] run_len_t;

	// Host command codes
	localparam cmd_code_t CMD_VIDEO_MODE = 8'h20;
	localparam cmd_code_t CMD_VSET       = 8'h27;
	localparam cmd_code_t CMD_HSET       = 8'h37;
	localparam cmd_code_t CMD_ARC        = 8'h3A;

	// Mode after reset is 1920 x 1080
	localparam coord_t DEFAULT_WIDTH  = 12'd1920;
	localparam coord_t DEFAULT_HEIGHT = 12'd1080;

	// Cycles per window calculation
	localparam int CALC_PHASES = 8;

	// Decoder states
	typedef enum logic {
		CMD_IDLE,
		CMD_ARGS
	} cmd_state_e;

endpackage
